/* hw/ahb_config.svh */
// AHB subsystem build-time configuration for bus widths, slave count and address map
`ifndef AHB_CONFIG_SVH
`define AHB_CONFIG_SVH

// ==============================
// Bus widths
// ==============================
`define AHB_ADDR_WIDTH 32
`define AHB_DATA_WIDTH 32

// Mapped slaves, default slave excluded
`define AHB_SLAVE_NUM 2

// ==============================
// Address map, inclusive bounds
// ==============================
`define PERI0_LOW  32'h0001_0000
`define PERI0_HIGH 32'h0001_001C
`define PERI1_LOW  32'h0002_0000
`define PERI1_HIGH 32'h0002_001C

// Word registers in each bank
`define PERI_REG_NUM 8

`endif

/* hw/ahb_pkg.sv */
// AHB subsystem types for bus vectors, transfer encodings and phase structs
`default_nettype none
`include "ahb_config.svh"

package ahb_pkg;

  // Plain bus vectors
  typedef logic [`AHB_ADDR_WIDTH-1:0] haddr_t;
  typedef logic [`AHB_DATA_WIDTH-1:0] hdata_t;
  // One select bit per mapped slave
  typedef logic [`AHB_SLAVE_NUM-1:0]  slave_sel_t;

  // AHB transfer type encodings
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Default slave FSM
  typedef enum logic [1:0] {
    DS_OKAY     = 2'b00,
    DS_ERR_WAIT = 2'b01,
    DS_ERR_LAST = 2'b10
  } dslv_state_e;

  // Address phase from the master
  typedef struct packed {
    haddr_t  haddr;
    htrans_e htrans;
    logic    hwrite;
  } ahb_addr_t;

  // Data phase response from a slave
  typedef struct packed {
    hdata_t hrdata;
    logic   hready_out;
    logic   hresp;
  } ahb_resp_t;

endpackage

`default_nettype wire

/* hw/ahb_decoder.sv */
// AHB address decoder matching haddr against inclusive slave windows
`timescale 1ns/1ps
`default_nettype none
`include "ahb_config.svh"

module ahb_decoder (
  input  ahb_pkg::ahb_addr_t  addr_phase,
  output ahb_pkg::slave_sel_t hsel,
  output logic                default_sel
);

  // ==============================
  // Address map
  // ==============================
  // Index 0 is bank 0, index 1 is bank 1
  localparam ahb_pkg::haddr_t low_addr [`AHB_SLAVE_NUM] = '{`PERI0_LOW, `PERI1_LOW};
  localparam ahb_pkg::haddr_t high_addr [`AHB_SLAVE_NUM] = '{`PERI0_HIGH, `PERI1_HIGH};

  ahb_pkg::slave_sel_t slave_detect;
  logic                active;

  // ==============================
  // Window compare
  // ==============================
  genvar i;
  generate
    for (i = 0; i < `AHB_SLAVE_NUM; i++) begin : g_window
      // Both bounds inclusive
      assign slave_detect[i] = (addr_phase.haddr >= low_addr[i]) &&
                               (addr_phase.haddr <= high_addr[i]);
    end
  endgenerate

  // Only NONSEQ and SEQ request a slave
  // IDLE and BUSY get the zero-wait OKAY instead
  assign active = (addr_phase.htrans == ahb_pkg::NONSEQ) ||
                  (addr_phase.htrans == ahb_pkg::SEQ);

  assign hsel = active ? slave_detect : '0;

  // Active transfer into a hole in the map
  assign default_sel = active && !(|slave_detect);

  // ==============================
  // Checks
  // ==============================
  // Windows must not overlap, and the default slave never shares a transfer
  always_comb begin
    assert ($onehot0(hsel))
      else $error("decoder: overlapping windows, hsel=%b", hsel);
    assert (!(default_sel && (|hsel)))
      else $error("decoder: default_sel together with hsel=%b", hsel);
  end

endmodule

`default_nettype wire

/* hw/ahb_periph_regs.sv */
// AHB peripheral bank of word-wide read/write registers with zero wait states
`timescale 1ns/1ps
`default_nettype none
`include "ahb_config.svh"

module ahb_periph_regs (
  input  logic               hclk,
  input  logic               arst_n,
  input  ahb_pkg::ahb_addr_t addr_phase,
  input  logic               hsel,
  input  logic               hready,
  input  ahb_pkg::hdata_t    hwdata,
  output ahb_pkg::ahb_resp_t resp
);

  // Word index width, taken from haddr above the byte offset
  localparam int idx_w = $clog2(`PERI_REG_NUM);

  ahb_pkg::hdata_t  regs [`PERI_REG_NUM];

  // Data phase state
  logic             dp_valid;
  logic             dp_write;
  logic [idx_w-1:0] dp_idx;

  logic             wr_en;
  logic             rd_en;

  // ==============================
  // Address phase capture
  // ==============================
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      dp_valid <= 1'b0;
      dp_write <= 1'b0;
    end else if (hready) begin
      // Cleared when the completing address phase is not ours
      dp_valid <= hsel;
      dp_write <= hsel && addr_phase.hwrite;
    end
  end

  // Word index, payload only
  always_ff @(posedge hclk) begin
    if (hsel && hready) begin
      dp_idx <= addr_phase.haddr[idx_w+1:2];
    end
  end

  // ==============================
  // Data phase
  // ==============================
  assign wr_en = dp_valid && dp_write;
  assign rd_en = dp_valid && !dp_write;

  // hwdata lands at the edge that ends the data phase
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < `PERI_REG_NUM; r++) begin
        regs[r] <= '0;
      end
    end else if (wr_en) begin
      regs[dp_idx] <= hwdata;
    end
  end

  // Read data straight from the array in N+1
  assign resp.hrdata     = rd_en ? regs[dp_idx] : '0;
  // Zero wait states, never an error
  assign resp.hready_out = 1'b1;
  assign resp.hresp      = 1'b0;

  // Index must stay inside the bank for any accepted transfer
  a_idx_range : assert property (
    @(posedge hclk) disable iff (!arst_n)
    dp_valid |-> (int'(dp_idx) < `PERI_REG_NUM)
  ) else $error("periph regs: index %0d out of range", dp_idx);

endmodule

`default_nettype wire

/* hw/ahb_default_slave.sv */
// AHB default slave answering unmapped transfers with the two-cycle ERROR response
`timescale 1ns/1ps
`default_nettype none

module ahb_default_slave (
  input  logic               hclk,
  input  logic               arst_n,
  input  logic               default_sel,
  input  logic               hready,
  output ahb_pkg::ahb_resp_t resp
);

  ahb_pkg::dslv_state_e state;
  ahb_pkg::dslv_state_e state_nxt;
  logic                 err_req;

  // Unmapped address phase accepted this cycle
  assign err_req = default_sel && hready;

  // ==============================
  // FSM
  // ==============================
  always_comb begin
    state_nxt = state;
    case (state)
      ahb_pkg::DS_OKAY:     if (err_req) state_nxt = ahb_pkg::DS_ERR_WAIT;
      // Second error cycle always follows
      ahb_pkg::DS_ERR_WAIT: state_nxt = ahb_pkg::DS_ERR_LAST;
      // Back-to-back errors skip DS_OKAY
      ahb_pkg::DS_ERR_LAST: state_nxt = err_req ? ahb_pkg::DS_ERR_WAIT : ahb_pkg::DS_OKAY;
      default:              state_nxt = ahb_pkg::DS_OKAY;
    endcase
  end

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ahb_pkg::DS_OKAY;
    end else begin
      state <= state_nxt;
    end
  end

  // ==============================
  // Response
  // ==============================
  // Wait state only in the first error cycle
  assign resp.hready_out = (state != ahb_pkg::DS_ERR_WAIT);
  // ERROR held across both cycles
  assign resp.hresp      = (state != ahb_pkg::DS_OKAY);
  // No readable data here
  assign resp.hrdata     = '0;

  // First error cycle must lead into the second
  a_err_two_cycle : assert property (
    @(posedge hclk) disable iff (!arst_n)
    (state == ahb_pkg::DS_ERR_WAIT) |=> (state == ahb_pkg::DS_ERR_LAST)
  ) else $error("default slave: DS_ERR_WAIT not followed by DS_ERR_LAST");

endmodule

`default_nettype wire

/* hw/ahb_resp_mux.sv */
// AHB response multiplexer steering the data-phase owner back to the master
`timescale 1ns/1ps
`default_nettype none

module ahb_resp_mux (
  input  logic                hclk,
  input  logic                arst_n,
  input  ahb_pkg::slave_sel_t hsel,
  input  logic                default_sel,
  input  ahb_pkg::ahb_resp_t  peri0_resp,
  input  ahb_pkg::ahb_resp_t  peri1_resp,
  input  ahb_pkg::ahb_resp_t  dflt_resp,
  output ahb_pkg::ahb_resp_t  resp
);

  // Data phase owner
  typedef enum logic [1:0] {
    OWN_NONE  = 2'b00,
    OWN_PERI0 = 2'b01,
    OWN_PERI1 = 2'b10,
    OWN_DFLT  = 2'b11
  } owner_e;

  owner_e owner;
  owner_e owner_nxt;

  // ==============================
  // Owner select
  // ==============================
  // Decoder guarantees at most one select
  always_comb begin
    if (default_sel)  owner_nxt = OWN_DFLT;
    else if (hsel[0]) owner_nxt = OWN_PERI0;
    else if (hsel[1]) owner_nxt = OWN_PERI1;
    else              owner_nxt = OWN_NONE;
  end

  // Advance only when the current data phase completes
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      owner <= OWN_NONE;
    end else if (resp.hready_out) begin
      owner <= owner_nxt;
    end
  end

  // ==============================
  // Response path
  // ==============================
  always_comb begin
    case (owner)
      OWN_PERI0: resp = peri0_resp;
      OWN_PERI1: resp = peri1_resp;
      OWN_DFLT:  resp = dflt_resp;
      // Idle OKAY with zero data
      default:   resp = '{hrdata: '0, hready_out: 1'b1, hresp: 1'b0};
    endcase
  end

  // Bus hready must always be resolved for the master
  a_hready_known : assert property (
    @(posedge hclk) disable iff (!arst_n)
    !$isunknown(resp.hready_out)
  ) else $error("resp mux: hready_out unknown");

endmodule

`default_nettype wire

/* hw/ahb_subsystem_top.sv */
// AHB subsystem top joining the decoder, two register banks, default slave and response mux
`timescale 1ns/1ps
`default_nettype none

module ahb_subsystem_top (
  input  logic               hclk,
  input  logic               arst_n,
  input  ahb_pkg::ahb_addr_t addr_phase,
  input  ahb_pkg::hdata_t    hwdata,
  output ahb_pkg::ahb_resp_t resp
);

  // Decode results
  ahb_pkg::slave_sel_t hsel;
  logic                default_sel;

  // Per-slave responses
  ahb_pkg::ahb_resp_t  peri0_resp;
  ahb_pkg::ahb_resp_t  peri1_resp;
  ahb_pkg::ahb_resp_t  dflt_resp;

  // Bus hready fed back to all slaves
  logic                hready;
  assign hready = resp.hready_out;

  // ==============================
  // Address decode
  // ==============================
  ahb_decoder u_decoder (
    .addr_phase  (addr_phase),
    .hsel        (hsel),
    .default_sel (default_sel)
  );

  // ==============================
  // Slaves
  // ==============================
  ahb_periph_regs u_peri0 (
    .hclk       (hclk),
    .arst_n     (arst_n),
    .addr_phase (addr_phase),
    .hsel       (hsel[0]),
    .hready     (hready),
    .hwdata     (hwdata),
    .resp       (peri0_resp)
  );

  ahb_periph_regs u_peri1 (
    .hclk       (hclk),
    .arst_n     (arst_n),
    .addr_phase (addr_phase),
    .hsel       (hsel[1]),
    .hready     (hready),
    .hwdata     (hwdata),
    .resp       (peri1_resp)
  );

  ahb_default_slave u_default_slave (
    .hclk        (hclk),
    .arst_n      (arst_n),
    .default_sel (default_sel),
    .hready      (hready),
    .resp        (dflt_resp)
  );

  // Data phase return path
  ahb_resp_mux u_resp_mux (
    .hclk        (hclk),
    .arst_n      (arst_n),
    .hsel        (hsel),
    .default_sel (default_sel),
    .peri0_resp  (peri0_resp),
    .peri1_resp  (peri1_resp),
    .dflt_resp   (dflt_resp),
    .resp        (resp)
  );

endmodule

`default_nettype wire

/* tests/tb_ahb_subsystem.sv */
// AHB subsystem testbench running directed transfers against a register model
`timescale 1ns/1ps
`default_nettype none
`include "ahb_config.svh"

module tb_ahb_subsystem;

  localparam int timeout_cycles = 50;
  localparam int model_size     = 2 * `PERI_REG_NUM;

  logic               hclk;
  logic               arst_n;
  ahb_pkg::ahb_addr_t addr_phase;
  ahb_pkg::hdata_t    hwdata;
  ahb_pkg::ahb_resp_t resp;

  // Bank 0 at 0..7, bank 1 at 8..15
  ahb_pkg::hdata_t    model [model_size];
  integer             seed = 32'h4dea_720a;

  ahb_subsystem_top DUT (
    .hclk       (hclk),
    .arst_n     (arst_n),
    .addr_phase (addr_phase),
    .hwdata     (hwdata),
    .resp       (resp)
  );

  // 20 ns clock
  always #10 hclk = ~hclk;

  // ==============================
  // Helpers
  // ==============================
  task automatic check_equal(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error [%s] %s: expected 0x%08h, actual 0x%08h",
               test, field, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic ahb_pkg::haddr_t reg_addr(input int bank, input int idx);
    ahb_pkg::haddr_t base;
    base = (bank == 0) ? `PERI0_LOW : `PERI1_LOW;
    return base + 32'(idx * 4);
  endfunction

  // Address phase for cycle N, driven just after the edge
  task automatic drive_addr(input ahb_pkg::haddr_t addr, input ahb_pkg::htrans_e trans,
                            input logic write);
    @(posedge hclk);
    #1;
    addr_phase = '{haddr: addr, htrans: trans, hwrite: write};
  endtask

  // Sample at the falling edge until the address phase can complete
  task automatic wait_hready(input string test);
    int cycles;
    cycles = 0;
    @(negedge hclk);
    while (!resp.hready_out) begin
      if (cycles == timeout_cycles) begin
        $display("Timeout in %s: hready stayed low for %0d cycles", test, cycles);
        $display("Simulation FAILED");
        $fatal(1, "hready timeout");
      end
      cycles++;
      @(negedge hclk);
    end
  endtask

  // Enter cycle N+1 with the bus idle
  task automatic enter_data_phase(input ahb_pkg::hdata_t data);
    @(posedge hclk);
    #1;
    addr_phase = '{haddr: '0, htrans: ahb_pkg::IDLE, hwrite: 1'b0};
    hwdata     = data;
    @(negedge hclk);
  endtask

  // ==============================
  // Master transfers
  // ==============================
  task automatic ahb_write(input string test, input ahb_pkg::haddr_t addr,
                           input ahb_pkg::hdata_t data);
    drive_addr(addr, ahb_pkg::NONSEQ, 1'b1);
    wait_hready(test);
    enter_data_phase(data);
    // Zero wait states expected
    check_equal(test, "write hready", 32'd1, 32'(resp.hready_out));
    check_equal(test, "write hresp", 32'd0, 32'(resp.hresp));
  endtask

  task automatic ahb_read(input string test, input ahb_pkg::haddr_t addr,
                          input ahb_pkg::hdata_t expected);
    drive_addr(addr, ahb_pkg::NONSEQ, 1'b0);
    wait_hready(test);
    // Junk on hwdata must be ignored by a read
    enter_data_phase($random(seed));
    check_equal(test, "read hready", 32'd1, 32'(resp.hready_out));
    check_equal(test, "read hresp", 32'd0, 32'(resp.hresp));
    check_equal(test, "hrdata", expected, resp.hrdata);
  endtask

  // Unmapped NONSEQ, two-cycle ERROR
  task automatic error_access(input string test, input ahb_pkg::haddr_t addr,
                              input logic write);
    drive_addr(addr, ahb_pkg::NONSEQ, write);
    wait_hready(test);
    enter_data_phase($random(seed));
    check_equal(test, "error cycle 1 hready", 32'd0, 32'(resp.hready_out));
    check_equal(test, "error cycle 1 hresp", 32'd1, 32'(resp.hresp));
    // IDLE held through the wait state
    @(negedge hclk);
    check_equal(test, "error cycle 2 hready", 32'd1, 32'(resp.hready_out));
    check_equal(test, "error cycle 2 hresp", 32'd1, 32'(resp.hresp));
  endtask

  // IDLE or BUSY with hwrite high, zero-wait OKAY
  task automatic idle_access(input string test, input ahb_pkg::haddr_t addr,
                             input ahb_pkg::htrans_e trans);
    drive_addr(addr, trans, 1'b1);
    wait_hready(test);
    enter_data_phase($random(seed));
    check_equal(test, "idle hready", 32'd1, 32'(resp.hready_out));
    check_equal(test, "idle hresp", 32'd0, 32'(resp.hresp));
    check_equal(test, "idle hrdata", 32'd0, resp.hrdata);
  endtask

  task automatic check_all_regs(input string test);
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < `PERI_REG_NUM; i++) begin
        ahb_read(test, reg_addr(b, i), model[b * `PERI_REG_NUM + i]);
      end
    end
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic test_reset_values();
    @(negedge hclk);
    check_equal("test_reset_values", "reset hready", 32'd1, 32'(resp.hready_out));
    check_equal("test_reset_values", "reset hresp", 32'd0, 32'(resp.hresp));
    check_all_regs("test_reset_values");
  endtask

  task automatic test_peri0_rw();
    ahb_pkg::hdata_t data;
    for (int i = 0; i < `PERI_REG_NUM; i++) begin
      data = $random(seed);
      ahb_write("test_peri0_rw", reg_addr(0, i), data);
      model[i] = data;
    end
    for (int i = 0; i < `PERI_REG_NUM; i++) begin
      ahb_read("test_peri0_rw", reg_addr(0, i), model[i]);
    end
  endtask

  task automatic test_bank_isolation();
    ahb_pkg::hdata_t data;
    for (int i = 0; i < `PERI_REG_NUM; i++) begin
      data = $random(seed);
      ahb_write("test_bank_isolation", reg_addr(1, i), data);
      model[`PERI_REG_NUM + i] = data;
    end
    // Bank 0 still holds its earlier contents
    check_all_regs("test_bank_isolation");
  endtask

  task automatic test_unmapped_error();
    error_access("test_unmapped_error", 32'h0003_0000, 1'b0);
    error_access("test_unmapped_error", 32'h0003_0000, 1'b1);
    check_all_regs("test_unmapped_error");
  endtask

  task automatic test_window_edges();
    ahb_pkg::hdata_t data;
    // Top word of each window is inside the map
    data = $random(seed);
    ahb_write("test_window_edges", `PERI0_HIGH, data);
    model[`PERI_REG_NUM - 1] = data;
    ahb_read("test_window_edges", `PERI0_HIGH, data);
    data = $random(seed);
    ahb_write("test_window_edges", `PERI1_HIGH, data);
    model[model_size - 1] = data;
    ahb_read("test_window_edges", `PERI1_HIGH, data);
    // One word outside either end
    error_access("test_window_edges", `PERI0_HIGH + 32'd4, 1'b0);
    error_access("test_window_edges", `PERI0_LOW - 32'd4, 1'b1);
    error_access("test_window_edges", `PERI1_HIGH + 32'd4, 1'b1);
    error_access("test_window_edges", `PERI1_LOW - 32'd4, 1'b0);
    check_all_regs("test_window_edges");
  endtask

  task automatic test_idle_busy();
    idle_access("test_idle_busy", `PERI0_LOW, ahb_pkg::IDLE);
    idle_access("test_idle_busy", `PERI1_HIGH, ahb_pkg::BUSY);
    idle_access("test_idle_busy", 32'h0003_0000, ahb_pkg::IDLE);
    idle_access("test_idle_busy", 32'h0003_0000, ahb_pkg::BUSY);
    check_all_regs("test_idle_busy");
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    hclk       = 1'b0;
    arst_n     = 1'b0;
    addr_phase = '{haddr: '0, htrans: ahb_pkg::IDLE, hwrite: 1'b0};
    hwdata     = '0;
    for (int i = 0; i < model_size; i++) begin
      model[i] = '0;
    end
    // Reset held for four cycles
    repeat (4) @(posedge hclk);
    #1;
    arst_n = 1'b1;

    test_reset_values();
    test_peri0_rw();
    test_bank_isolation();
    test_unmapped_error();
    test_window_edges();
    test_idle_busy();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
hw/ahb_pkg.sv
hw/ahb_decoder.sv
hw/ahb_periph_regs.sv
hw/ahb_default_slave.sv
hw/ahb_resp_mux.sv
hw/ahb_subsystem_top.sv
tests/tb_ahb_subsystem.sv

/* Makefile */
# Verilator build and run of the AHB subsystem testbench

TOP = tb_ahb_subsystem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f project.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
